/* build.f */
mem_pkg.sv
mem_address_unit.sv
store_data_formatter.sv
memory_access_stage.sv
tb_memory_access_stage.sv

/* mem_address_unit.sv */
// Address path of the memory access stage
// Effective pointer for scalar, block, strided and scatter/gather access
// Cache line address, cache lane, word mask and alignment check

module mem_address_unit
(
	input  logic [3:0] op,
	input  mem_pkg::lane_vector_t address,
	input  logic [31:0] base_addr,
	input  logic [31:0] strided_offset,
	input  mem_pkg::word_mask_t mask,
	input  logic [3:0] reg_lane,
	output mem_pkg::line_addr_t line_addr,
	output logic [3:0] cache_lane,
	output mem_pkg::word_mask_t word_mask,
	output logic misaligned
);

	logic [31:0] strided_ptr;
	logic [31:0] gather_ptr;
	logic [31:0] ptr;
	logic is_block;
	logic is_lane_op;
	mem_pkg::word_mask_t lane_bit;

	assign is_block = mem_pkg::is_block_op(op);
	assign is_lane_op = mem_pkg::is_strided_op(op) || mem_pkg::is_scgath_op(op);

	assign strided_ptr = base_addr + strided_offset;
	assign gather_ptr = mem_pkg::lane_word(address, reg_lane);	// One address per lane

	always_comb
	begin
		if (mem_pkg::is_strided_op(op))
			ptr = strided_ptr;
		else if (mem_pkg::is_scgath_op(op))
			ptr = gather_ptr;
		else
			ptr = address[0];	// Scalar and block use the low word
	end

	assign line_addr = ptr[31:6];
	assign cache_lane = ptr[5:2];

	// Word 0 sits in bit 15
	assign lane_bit = mem_pkg::word_mask_t'(16'h8000 >> cache_lane);

	always_comb
	begin
		if (is_block)
			word_mask = mask;
		else if (is_lane_op)
			word_mask = mask[reg_lane] ? lane_bit : '0;	// Only if this lane is active
		else
			word_mask = lane_bit;
	end

	// Required alignment follows the access size
	always_comb
	begin
		case (op)
			mem_pkg::mem_b, mem_pkg::mem_bx:
				misaligned = 1'b0;

			mem_pkg::mem_s, mem_pkg::mem_sx:
				misaligned = ptr[0];

			mem_pkg::mem_l, mem_pkg::mem_sync, mem_pkg::mem_control_reg,
			mem_pkg::mem_strided, mem_pkg::mem_strided_m, mem_pkg::mem_strided_im,
			mem_pkg::mem_scgath, mem_pkg::mem_scgath_m, mem_pkg::mem_scgath_im:
				misaligned = ptr[1:0] != 2'b00;

			default:
				misaligned = ptr[5:0] != 6'd0;	// Whole line
		endcase
	end

endmodule

/* mem_pkg.sv */
// Shared definitions for the memory access stage
// Instruction format codes, memory and cache opcodes
// Line, mask and address types for a 16 lane, 512-bit cache line
// Opcode class helpers and lane word extraction

package mem_pkg;

	localparam int num_lanes = 16;

	typedef logic [num_lanes-1:0][31:0] lane_vector_t;	// Lane 15 in the top bits
	typedef logic [num_lanes*4-1:0] store_mask_t;		// Bit 63 is byte 0 of word 0
	typedef logic [25:0] line_addr_t;
	typedef logic [num_lanes-1:0] word_mask_t;		// Bit 15 is word 0

	// Format selectors
	localparam logic [1:0] fmt_c_code = 2'b10;
	localparam logic [3:0] fmt_d_code = 4'b1110;

	// Top half of an IO address
	localparam logic [15:0] io_page = 16'hffff;

	// Format C memory opcodes
	localparam logic [3:0] mem_b = 4'd0;
	localparam logic [3:0] mem_bx = 4'd1;
	localparam logic [3:0] mem_s = 4'd2;
	localparam logic [3:0] mem_sx = 4'd3;
	localparam logic [3:0] mem_l = 4'd4;
	localparam logic [3:0] mem_sync = 4'd5;
	localparam logic [3:0] mem_control_reg = 4'd6;
	localparam logic [3:0] mem_block = 4'd7;
	localparam logic [3:0] mem_block_m = 4'd8;
	localparam logic [3:0] mem_block_im = 4'd9;
	localparam logic [3:0] mem_strided = 4'd10;
	localparam logic [3:0] mem_strided_m = 4'd11;
	localparam logic [3:0] mem_strided_im = 4'd12;
	localparam logic [3:0] mem_scgath = 4'd13;
	localparam logic [3:0] mem_scgath_m = 4'd14;
	localparam logic [3:0] mem_scgath_im = 4'd15;

	// Format D cache opcodes
	localparam logic [2:0] cache_dinvalidate = 3'd1;
	localparam logic [2:0] cache_iinvalidate = 3'd2;
	localparam logic [2:0] cache_dflush = 3'd3;
	localparam logic [2:0] cache_stbar = 3'd4;

	localparam logic [31:0] nop_instruction = 32'd0;

	function automatic logic is_block_op(input logic [3:0] op);
		return op == mem_block || op == mem_block_m || op == mem_block_im;
	endfunction

	function automatic logic is_strided_op(input logic [3:0] op);
		return op == mem_strided || op == mem_strided_m || op == mem_strided_im;
	endfunction

	function automatic logic is_scgath_op(input logic [3:0] op);
		return op == mem_scgath || op == mem_scgath_m || op == mem_scgath_im;
	endfunction

	// Index 0 picks the top word of the vector
	function automatic logic [31:0] lane_word(input lane_vector_t value,
		input logic [3:0] lane);
		logic [3:0] slot;

		slot = 4'(num_lanes - 1) - lane;
		return value[slot];
	endfunction

endpackage

/* memory_access_stage.sv */
// Memory access stage of the vector core
// Instruction decode, cache, IO and control register strobes
// Byte store mask from the address and store data units
// Writeback register with squash and alignment fault

module memory_access_stage
(
	input  logic clk,
	input  logic reset,
	input  logic squash_ma,

	// Execute stage
	input  logic [31:0] ex_instruction,
	input  logic [1:0] ex_strand,
	input  mem_pkg::lane_vector_t ex_store_value,
	input  logic [6:0] ex_writeback_reg,
	input  logic ex_enable_scalar_writeback,
	input  logic ex_enable_vector_writeback,
	input  logic [31:0] ex_pc,
	input  mem_pkg::word_mask_t ex_mask,
	input  mem_pkg::lane_vector_t ex_result,
	input  logic [3:0] ex_reg_lane_select,
	input  logic [31:0] ex_strided_offset,
	input  logic [31:0] ex_base_addr,

	// Writeback stage
	output logic [1:0] ma_strand,
	output logic [31:0] ma_instruction,
	output logic [31:0] ma_pc,
	output logic [6:0] ma_writeback_reg,
	output logic ma_enable_scalar_writeback,
	output logic ma_enable_vector_writeback,
	output mem_pkg::word_mask_t ma_mask,
	output mem_pkg::lane_vector_t ma_result,
	output logic [3:0] ma_reg_lane_select,
	output logic [3:0] ma_cache_lane_select,
	output logic ma_was_load,
	output logic [31:0] ma_strided_offset,
	output logic ma_alignment_fault,
	output logic ma_was_io,

	// Control registers
	output logic [4:0] cr_index,
	output logic cr_read_en,
	output logic cr_write_en,
	output logic [31:0] cr_write_value,
	input  logic [31:0] cr_read_value,

	// Memory mapped IO
	output logic io_read_en,
	output logic io_write_en,
	output logic [31:0] io_address,
	output logic [31:0] io_write_data,

	// Data cache
	output mem_pkg::line_addr_t dcache_addr,
	output logic dcache_req_sync,
	output logic [1:0] dcache_req_strand,
	output mem_pkg::lane_vector_t data_to_dcache,
	output logic dcache_load,
	output logic dcache_store,
	output logic dcache_flush,
	output logic dcache_stbar,
	output logic dcache_dinvalidate,
	output logic dcache_iinvalidate,
	output mem_pkg::store_mask_t dcache_store_mask
);

	logic is_fmt_c;
	logic is_fmt_d;
	logic is_load;
	logic [3:0] c_op;
	logic [2:0] d_op;
	logic is_cr_transfer;
	logic lane_enabled;
	logic do_load_store;
	logic is_io_address;
	logic bad_io;
	logic bad_memory_access;
	logic misaligned;
	logic [3:0] cache_lane;
	logic [3:0] byte_mask;
	mem_pkg::word_mask_t word_mask;
	mem_pkg::lane_vector_t result_nxt;

	assign is_fmt_c = ex_instruction[31:30] == mem_pkg::fmt_c_code;
	assign is_fmt_d = ex_instruction[31:28] == mem_pkg::fmt_d_code;
	assign is_load = ex_instruction[29];
	assign c_op = ex_instruction[28:25];
	assign d_op = ex_instruction[27:25];

	mem_address_unit i_address
	(
		.op(c_op),
		.address(ex_result),
		.base_addr(ex_base_addr),
		.strided_offset(ex_strided_offset),
		.mask(ex_mask),
		.reg_lane(ex_reg_lane_select),
		.line_addr(dcache_addr),
		.cache_lane(cache_lane),
		.word_mask(word_mask),
		.misaligned(misaligned)
	);

	store_data_formatter i_store_data
	(
		.op(c_op),
		.addr_low(ex_result[0][1:0]),
		.store_value(ex_store_value),
		.reg_lane(ex_reg_lane_select),
		.byte_mask(byte_mask),
		.data_to_dcache(data_to_dcache)
	);

	assign is_cr_transfer = is_fmt_c && c_op == mem_pkg::mem_control_reg;

	// Block ops need any lane, others their own lane
	assign lane_enabled = mem_pkg::is_block_op(c_op) ? ex_mask != '0
		: ex_mask[ex_reg_lane_select];

	assign do_load_store = is_fmt_c && !is_cr_transfer && !squash_ma && lane_enabled
		&& !misaligned;

	assign is_io_address = ex_result[0][31:16] == mem_pkg::io_page;
	assign bad_io = is_io_address && c_op != mem_pkg::mem_l;	// IO is word access only
	assign bad_memory_access = is_fmt_c && !is_cr_transfer && !squash_ma
		&& (misaligned || bad_io);

	assign io_read_en = do_load_store && is_load && is_io_address;
	assign io_write_en = do_load_store && !is_load && is_io_address;
	assign io_address = {16'd0, ex_result[0][15:0]};
	assign io_write_data = ex_store_value[0];

	assign dcache_load = do_load_store && is_load && !is_io_address;
	assign dcache_store = do_load_store && !is_load && !is_io_address;
	assign dcache_req_sync = c_op == mem_pkg::mem_sync;
	assign dcache_req_strand = ex_strand;

	// Cache control from format D
	assign dcache_flush = is_fmt_d && d_op == mem_pkg::cache_dflush && !squash_ma;
	assign dcache_stbar = is_fmt_d && d_op == mem_pkg::cache_stbar && !squash_ma;
	assign dcache_dinvalidate = is_fmt_d && d_op == mem_pkg::cache_dinvalidate && !squash_ma;
	assign dcache_iinvalidate = is_fmt_d && d_op == mem_pkg::cache_iinvalidate && !squash_ma;

	// Bit 63 is byte 0 of word 0
	always_comb
	begin
		for (int w = 0; w < mem_pkg::num_lanes; w++)
		begin
			for (int b = 0; b < 4; b++)
				dcache_store_mask[w * 4 + b] = word_mask[w] & byte_mask[b];
		end
	end

	assign cr_index = ex_instruction[4:0];
	assign cr_read_en = is_cr_transfer && is_load;
	assign cr_write_en = is_cr_transfer && !is_load && !squash_ma;
	assign cr_write_value = ex_store_value[0];

	always_comb
	begin
		result_nxt = ex_result;
		if (is_cr_transfer)
		begin
			result_nxt = '0;
			result_nxt[0] = cr_read_value;	// Scalar result in the low word
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			ma_strand <= '0;
			ma_instruction <= '0;
			ma_pc <= '0;
			ma_writeback_reg <= '0;
			ma_enable_scalar_writeback <= 1'b0;
			ma_enable_vector_writeback <= 1'b0;
			ma_mask <= '0;
			ma_result <= '0;
			ma_reg_lane_select <= '0;
			ma_cache_lane_select <= '0;
			ma_was_load <= 1'b0;
			ma_strided_offset <= '0;
			ma_alignment_fault <= 1'b0;
			ma_was_io <= 1'b0;
		end
		else
		begin
			ma_strand <= ex_strand;
			ma_pc <= ex_pc;
			ma_writeback_reg <= ex_writeback_reg;
			ma_mask <= ex_mask;
			ma_result <= result_nxt;
			ma_reg_lane_select <= ex_reg_lane_select;
			ma_cache_lane_select <= cache_lane;
			ma_was_load <= dcache_load;
			ma_strided_offset <= ex_strided_offset;
			ma_was_io <= is_io_address;

			if (squash_ma)
			begin
				ma_instruction <= mem_pkg::nop_instruction;
				ma_enable_scalar_writeback <= 1'b0;
				ma_enable_vector_writeback <= 1'b0;
				ma_alignment_fault <= 1'b0;
			end
			else
			begin
				ma_instruction <= ex_instruction;
				ma_enable_scalar_writeback <= ex_enable_scalar_writeback;
				ma_enable_vector_writeback <= ex_enable_vector_writeback;
				ma_alignment_fault <= bad_memory_access;
			end
		end
	end

endmodule

/* run_sim.sh */
#!/bin/sh
# Compile and run the memory access stage testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir

verilator --binary --timing --timescale 1ns/100ps -f build.f \
	--top-module tb_memory_access_stage -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "Verilator build failed, see build.log"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
fi

if grep -qx ">>> PASS" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see sim.log"
	exit 1
fi

/* store_data_formatter.sv */
// Store data path of the memory access stage
// Per-word byte enables from access size and low address bits
// Byte-swapped store data, replicated across the line or swapped per word

module store_data_formatter
(
	input  logic [3:0] op,
	input  logic [1:0] addr_low,
	input  mem_pkg::lane_vector_t store_value,
	input  logic [3:0] reg_lane,
	output logic [3:0] byte_mask,
	output mem_pkg::lane_vector_t data_to_dcache
);

	logic [31:0] lane_value;
	logic [31:0] scalar_value;
	logic [31:0] fill_word;
	logic per_word;

	// Register values are little endian, memory is big endian
	function automatic logic [31:0] byte_swap(input logic [31:0] value);
		return {value[7:0], value[15:8], value[23:16], value[31:24]};
	endfunction

	assign scalar_value = store_value[0];
	assign lane_value = mem_pkg::lane_word(store_value, reg_lane);

	always_comb
	begin
		byte_mask = 4'b1111;
		fill_word = byte_swap(scalar_value);
		per_word = 1'b0;

		case (op)
			mem_pkg::mem_b, mem_pkg::mem_bx:
			begin
				byte_mask = 4'b1000 >> addr_low;
				fill_word = {scalar_value[7:0], 24'd0} >> {addr_low, 3'b000};
			end

			mem_pkg::mem_s, mem_pkg::mem_sx:
			begin
				if (!addr_low[1])
				begin
					byte_mask = 4'b1100;	// Upper half of the word
					fill_word = {scalar_value[7:0], scalar_value[15:8], 16'd0};
				end
				else
				begin
					byte_mask = 4'b0011;
					fill_word = {16'd0, scalar_value[7:0], scalar_value[15:8]};
				end
			end

			mem_pkg::mem_l, mem_pkg::mem_sync, mem_pkg::mem_control_reg:
				fill_word = byte_swap(scalar_value);

			mem_pkg::mem_strided, mem_pkg::mem_strided_m, mem_pkg::mem_strided_im,
			mem_pkg::mem_scgath, mem_pkg::mem_scgath_m, mem_pkg::mem_scgath_im:
				fill_word = byte_swap(lane_value);	// Current lane only

			default:
				per_word = 1'b1;	// Block store
		endcase
	end

	// Word mask later picks which replicated copy is written
	always_comb
	begin
		for (int i = 0; i < mem_pkg::num_lanes; i++)
		begin
			if (per_word)
				data_to_dcache[i] = byte_swap(store_value[i]);
			else
				data_to_dcache[i] = fill_word;
		end
	end

endmodule

/* tb_memory_access_stage.sv */
// Testbench for the memory access stage
// Clock, reset and LFSR driven stimulus for every access kind
// Reference model of strobes, store data and writeback fields, compare tasks

module tb_memory_access_stage;

	timeunit 1ns;
	timeprecision 100ps;

	typedef struct packed
	{
		mem_pkg::line_addr_t addr;
		mem_pkg::lane_vector_t data;
		mem_pkg::store_mask_t store_mask;
		mem_pkg::lane_vector_t result;
		logic [31:0] instruction;
		logic [4:0] cr_index;
		logic [31:0] io_address;
		logic [31:0] io_data;
		logic [31:0] cr_data;
		logic [1:0] strand;
		logic [31:0] pc;
		logic [6:0] wb_reg;
		mem_pkg::word_mask_t mask;
		logic [3:0] reg_lane;
		logic [3:0] cache_lane;
		logic [31:0] offset;
		logic was_io;
		logic load;
		logic store;
		logic io_read;
		logic io_write;
		logic cr_read;
		logic cr_write;
		logic flush;
		logic stbar;
		logic dinvalidate;
		logic iinvalidate;
		logic sync;
		logic fault;
		logic en_scalar;
		logic en_vector;
	} expect_t;

	logic clk;
	logic reset = 1'b1;
	logic squash_ma;
	logic [31:0] ex_instruction;
	logic [1:0] ex_strand;
	mem_pkg::lane_vector_t ex_store_value;
	logic [6:0] ex_writeback_reg;
	logic ex_enable_scalar_writeback;
	logic ex_enable_vector_writeback;
	logic [31:0] ex_pc;
	mem_pkg::word_mask_t ex_mask;
	mem_pkg::lane_vector_t ex_result;
	logic [3:0] ex_reg_lane_select;
	logic [31:0] ex_strided_offset;
	logic [31:0] ex_base_addr;
	logic [31:0] cr_read_value;
	logic [1:0] ma_strand;
	logic [31:0] ma_instruction;
	logic [31:0] ma_pc;
	logic [6:0] ma_writeback_reg;
	logic ma_enable_scalar_writeback;
	logic ma_enable_vector_writeback;
	mem_pkg::word_mask_t ma_mask;
	mem_pkg::lane_vector_t ma_result;
	logic [3:0] ma_reg_lane_select;
	logic [3:0] ma_cache_lane_select;
	logic ma_was_load;
	logic [31:0] ma_strided_offset;
	logic ma_alignment_fault;
	logic ma_was_io;
	logic [4:0] cr_index;
	logic cr_read_en;
	logic cr_write_en;
	logic [31:0] cr_write_value;
	logic io_read_en;
	logic io_write_en;
	logic [31:0] io_address;
	logic [31:0] io_write_data;
	mem_pkg::line_addr_t dcache_addr;
	logic dcache_req_sync;
	logic [1:0] dcache_req_strand;
	mem_pkg::lane_vector_t data_to_dcache;
	logic dcache_load;
	logic dcache_store;
	logic dcache_flush;
	logic dcache_stbar;
	logic dcache_dinvalidate;
	logic dcache_iinvalidate;
	mem_pkg::store_mask_t dcache_store_mask;

	logic [15:0] lfsr_state = 16'd52;
	expect_t exp_now;
	logic now_valid = 1'b0;	// exp_now describes the current inputs
	logic stim_done = 1'b0;
	logic checks_done = 1'b0;

	memory_access_stage i_dut (.*);

	initial
	begin
		clk = 1'b0;
		forever
			#2 clk = ~clk;
	end

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display(">>> FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_mask(input string name, input mem_pkg::store_mask_t got,
		input mem_pkg::store_mask_t exp);
		if (got !== exp)
			fail_run($sformatf("error %s: got %h expected %h", name, got, exp));
	endtask

	task automatic check_line(input string name, input mem_pkg::lane_vector_t got,
		input mem_pkg::lane_vector_t exp);
		if (got !== exp)
			fail_run($sformatf("error %s: got %h expected %h", name, got, exp));
	endtask

	task automatic check_addr(input string name, input mem_pkg::line_addr_t got,
		input mem_pkg::line_addr_t exp);
		if (got !== exp)
			fail_run($sformatf("error %s: got %h expected %h", name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_run($sformatf("error %s: got %h expected %h", name, got, exp));
	endtask

	task automatic check_word(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
			fail_run($sformatf("error %s: got %h expected %h", name, got, exp));
	endtask

	// Fibonacci LFSR, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
	endfunction

	task automatic take_bits(input int count, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < count; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
	endtask

	task automatic take_vector(output mem_pkg::lane_vector_t value);
		logic [31:0] r;

		for (int w = 0; w < mem_pkg::num_lanes; w++)
		begin
			take_bits(32, r);
			value[w] = r;
		end
	endtask

	function automatic logic [31:0] swap_bytes(input logic [31:0] value);
		return {value[7:0], value[15:8], value[23:16], value[31:24]};
	endfunction

	function automatic logic [31:0] make_c(input logic load, input logic [3:0] op,
		input logic [4:0] index);
		return {2'b10, load, op, 20'd0, index};
	endfunction

	function automatic logic [31:0] make_d(input logic [2:0] op);
		return {4'b1110, op, 25'd0};
	endfunction

	// Expected outputs for one set of execute stage inputs
	function automatic expect_t predict(input logic [31:0] instr, input mem_pkg::word_mask_t mask,
		input mem_pkg::lane_vector_t result, input mem_pkg::lane_vector_t store_value,
		input logic [3:0] lane, input logic [31:0] base, input logic [31:0] offset,
		input logic [31:0] cr_value, input logic squash, input logic en_scalar,
		input logic en_vector, input logic [1:0] strand, input logic [31:0] pc,
		input logic [6:0] wb_reg);
		expect_t e;
		logic [3:0] op;
		logic [2:0] d_op;
		logic fmt_c;
		logic fmt_d;
		logic is_cr;
		logic block;
		logic lane_op;
		logic misaligned;
		logic io;
		logic go;
		logic [31:0] ptr;
		logic [31:0] value;
		logic [31:0] fill;
		logic [3:0] bytes;
		mem_pkg::word_mask_t words;

		op = instr[28:25];
		d_op = instr[27:25];
		fmt_c = instr[31:30] == 2'b10;
		fmt_d = instr[31:28] == 4'b1110;
		is_cr = fmt_c && op == mem_pkg::mem_control_reg;
		block = op >= 4'd7 && op <= 4'd9;
		lane_op = op >= 4'd10;	// Strided and scatter/gather
		value = store_value[0];

		if (op >= 4'd13)
			ptr = mem_pkg::lane_word(result, lane);
		else if (op >= 4'd10)
			ptr = base + offset;
		else
			ptr = result[0];

		// Alignment by access size
		if (op <= 4'd1)
			misaligned = 1'b0;
		else if (op <= 4'd3)
			misaligned = ptr[0];
		else if (block)
			misaligned = ptr[5:0] != 6'd0;
		else
			misaligned = ptr[1:0] != 2'b00;

		words = '0;
		words[15 - int'(ptr[5:2])] = 1'b1;	// Word 0 is bit 15
		if (block)
			words = mask;
		else if (lane_op && !mask[lane])
			words = '0;

		bytes = 4'b1111;
		fill = swap_bytes(value);
		if (op <= 4'd1)
		begin
			bytes = '0;
			bytes[3 - int'(ptr[1:0])] = 1'b1;
			fill = '0;
			fill[31 - 8 * int'(ptr[1:0]) -: 8] = value[7:0];
		end
		else if (op <= 4'd3)
		begin
			bytes = ptr[1] ? 4'b0011 : 4'b1100;
			fill = ptr[1] ? {16'd0, value[7:0], value[15:8]} : {value[7:0], value[15:8], 16'd0};
		end
		else if (lane_op)
			fill = swap_bytes(mem_pkg::lane_word(store_value, lane));

		for (int w = 0; w < mem_pkg::num_lanes; w++)
			e.data[w] = block ? swap_bytes(store_value[w]) : fill;

		// Byte j of word w, byte 0 of word 0 in bit 63
		for (int w = 0; w < 16; w++)
		begin
			for (int j = 0; j < 4; j++)
				e.store_mask[63 - 4 * w - j] = words[15 - w] & bytes[3 - j];
		end

		io = result[0][31:16] == 16'hffff;
		go = fmt_c && !is_cr && !squash && !misaligned && (block ? mask != '0 : mask[lane]);
		e.addr = ptr[31:6];
		e.load = go && instr[29] && !io;
		e.store = go && !instr[29] && !io;
		e.io_read = go && instr[29] && io;
		e.io_write = go && !instr[29] && io;
		e.cr_read = is_cr && instr[29];
		e.cr_write = is_cr && !instr[29] && !squash;
		e.cr_index = instr[4:0];
		e.flush = fmt_d && d_op == 3'd3 && !squash;
		e.stbar = fmt_d && d_op == 3'd4 && !squash;
		e.dinvalidate = fmt_d && d_op == 3'd1 && !squash;
		e.iinvalidate = fmt_d && d_op == 3'd2 && !squash;
		e.sync = op == mem_pkg::mem_sync;
		e.fault = fmt_c && !is_cr && !squash && (misaligned || (io && op != mem_pkg::mem_l));
		e.instruction = squash ? 32'd0 : instr;
		e.en_scalar = en_scalar && !squash;
		e.en_vector = en_vector && !squash;
		e.result = result;
		if (is_cr)
		begin
			e.result = '0;
			e.result[0] = cr_value;
		end
		e.io_address = {16'd0, result[0][15:0]};	// Offset within the IO page
		e.io_data = value;
		e.cr_data = value;
		e.strand = strand;
		e.pc = pc;
		e.wb_reg = wb_reg;
		e.mask = mask;
		e.reg_lane = lane;
		e.cache_lane = ptr[5:2];
		e.offset = offset;
		e.was_io = io;
		return e;
	endfunction

	// New random inputs 1 ns after the edge
	task automatic start_cycle();
		logic [31:0] r;

		@(posedge clk);
		#1;
		take_vector(ex_store_value);
		take_vector(ex_result);
		take_bits(32, r);
		ex_base_addr = r;
		take_bits(32, r);
		ex_strided_offset = r;
		take_bits(32, r);
		cr_read_value = r;
		take_bits(32, r);
		ex_pc = r;
		take_bits(16, r);
		ex_mask = r[15:0];
		take_bits(15, r);
		ex_reg_lane_select = r[3:0];
		ex_strand = r[5:4];
		ex_writeback_reg = r[12:6];
		ex_enable_scalar_writeback = r[13];
		ex_enable_vector_writeback = r[14];
		squash_ma = 1'b0;
	endtask

	task automatic settle();
		exp_now = predict(ex_instruction, ex_mask, ex_result, ex_store_value, ex_reg_lane_select,
			ex_base_addr, ex_strided_offset, cr_read_value, squash_ma,
			ex_enable_scalar_writeback, ex_enable_vector_writeback, ex_strand, ex_pc,
			ex_writeback_reg);
		now_valid = 1'b1;
	endtask

	initial
	begin : drive_stimulus
		logic [3:0] op;
		logic [31:0] r;
		int wait_cycles;

		squash_ma = 1'b0;
		ex_instruction = '0;
		ex_strand = '0;
		ex_store_value = '0;
		ex_writeback_reg = '0;
		ex_enable_scalar_writeback = 1'b0;
		ex_enable_vector_writeback = 1'b0;
		ex_pc = '0;
		ex_mask = '0;
		ex_result = '0;
		ex_reg_lane_select = '0;
		ex_strided_offset = '0;
		ex_base_addr = '0;
		cr_read_value = '0;
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;

		// Scalar stores at aligned addresses, the last few as loads
		for (int i = 0; i < 24; i++)
		begin
			start_cycle();
			op = i % 3 == 0 ? mem_pkg::mem_b : i % 3 == 1 ? mem_pkg::mem_s : mem_pkg::mem_l;
			ex_instruction = make_c(i >= 18, op, 5'd0);
			ex_result[0][31] = 1'b0;
			if (op == mem_pkg::mem_s)
				ex_result[0][0] = 1'b0;
			else if (op == mem_pkg::mem_l)
				ex_result[0][1:0] = 2'b00;
			ex_mask = '1;
			settle();
		end

		// Misaligned accesses, the last few squashed
		for (int i = 0; i < 12; i++)
		begin
			start_cycle();
			op = i % 3 == 0 ? mem_pkg::mem_s : i % 3 == 1 ? mem_pkg::mem_l : mem_pkg::mem_block;
			ex_instruction = make_c(i[0], op, 5'd0);
			ex_result[0][31] = 1'b0;
			ex_result[0][0] = 1'b1;
			ex_mask = '1;
			squash_ma = i >= 8;
			settle();
		end

		for (int i = 0; i < 12; i++)
		begin
			start_cycle();
			op = mem_pkg::mem_block + 4'(i % 3);
			ex_instruction = make_c(1'b0, op, 5'd0);
			ex_result[0][31] = 1'b0;
			ex_result[0][5:0] = 6'd0;
			if (i == 0)
				ex_mask = '0;	// No lane active
			settle();
		end

		// Strided and scatter/gather stores
		for (int i = 0; i < 24; i++)
		begin
			start_cycle();
			op = mem_pkg::mem_strided + 4'(i % 6);
			ex_instruction = make_c(1'b0, op, 5'd0);
			for (int w = 0; w < mem_pkg::num_lanes; w++)
				ex_result[w][1:0] = 2'b00;
			ex_result[0][31] = 1'b0;
			ex_base_addr[1:0] = 2'b00;
			ex_strided_offset[1:0] = 2'b00;
			settle();
		end

		// IO page accesses, then control register transfers
		for (int i = 0; i < 16; i++)
		begin
			start_cycle();
			take_bits(5, r);
			if (i < 8)
			begin
				op = i % 4 == 3 ? mem_pkg::mem_s : mem_pkg::mem_l;
				ex_result[0][31:16] = 16'hffff;
				ex_result[0][1:0] = 2'b00;
				ex_mask = '1;
			end
			else
				op = mem_pkg::mem_control_reg;
			ex_instruction = make_c(i[0], op, r[4:0]);
			settle();
		end

		for (int i = 0; i < 24; i++)
		begin
			start_cycle();
			if (i < 8)
			begin
				op = i % 2 == 0 ? mem_pkg::mem_l : mem_pkg::mem_control_reg;
				ex_instruction = make_c(i[1], op, 5'd3);
				ex_result[0][1:0] = 2'b00;
				ex_mask = '1;
				squash_ma = 1'b1;
			end
			else
			begin
				ex_instruction = make_d(3'(i));	// All cache opcodes
				squash_ma = i >= 16;
			end
			settle();
		end

		start_cycle();
		ex_instruction = mem_pkg::nop_instruction;
		settle();
		@(posedge clk);
		#1;
		stim_done = 1'b1;

		wait_cycles = 0;
		while (!checks_done)
		begin
			@(posedge clk);
			wait_cycles++;
			if (wait_cycles > 10)
				fail_run("compare process did not finish within 10 cycles");
		end
		$display(">>> PASS");
		$finish;
	end

	// Combinational outputs late in the cycle, ma outputs for the previous cycle
	initial
	begin : compare_outputs
		expect_t exp_reg;
		logic reg_valid;
		int cycles;

		#3;
		check_word("ma_instruction", ma_instruction, 32'd0);
		check_bit("ma_alignment_fault", ma_alignment_fault, 1'b0);
		check_bit("ma_enable_scalar_writeback", ma_enable_scalar_writeback, 1'b0);
		check_bit("ma_enable_vector_writeback", ma_enable_vector_writeback, 1'b0);

		cycles = 0;
		while (reset)
		begin
			@(posedge clk);
			cycles++;
			if (cycles > 20)
				fail_run("reset was not released within 20 cycles");
		end

		cycles = 0;
		while (!stim_done)
		begin
			exp_reg = exp_now;
			reg_valid = now_valid;
			#3.5;
			if (now_valid)
			begin
				check_bit("dcache_load", dcache_load, exp_now.load);
				check_bit("dcache_store", dcache_store, exp_now.store);
				check_bit("io_read_en", io_read_en, exp_now.io_read);
				check_bit("io_write_en", io_write_en, exp_now.io_write);
				check_bit("cr_read_en", cr_read_en, exp_now.cr_read);
				check_bit("cr_write_en", cr_write_en, exp_now.cr_write);
				check_bit("dcache_flush", dcache_flush, exp_now.flush);
				check_bit("dcache_stbar", dcache_stbar, exp_now.stbar);
				check_bit("dcache_dinvalidate", dcache_dinvalidate, exp_now.dinvalidate);
				check_bit("dcache_iinvalidate", dcache_iinvalidate, exp_now.iinvalidate);
				check_bit("dcache_req_sync", dcache_req_sync, exp_now.sync);
				check_word("cr_index", 32'(cr_index), 32'(exp_now.cr_index));
				check_word("cr_write_value", cr_write_value, exp_now.cr_data);
				check_word("io_address", io_address, exp_now.io_address);
				check_word("io_write_data", io_write_data, exp_now.io_data);
				check_word("dcache_req_strand", 32'(dcache_req_strand), 32'(exp_now.strand));
				check_addr("dcache_addr", dcache_addr, exp_now.addr);
				check_line("data_to_dcache", data_to_dcache, exp_now.data);
				check_mask("dcache_store_mask", dcache_store_mask, exp_now.store_mask);
			end
			if (reg_valid)
			begin
				check_word("ma_instruction", ma_instruction, exp_reg.instruction);
				check_bit("ma_enable_scalar_writeback", ma_enable_scalar_writeback,
					exp_reg.en_scalar);
				check_bit("ma_enable_vector_writeback", ma_enable_vector_writeback,
					exp_reg.en_vector);
				check_bit("ma_alignment_fault", ma_alignment_fault, exp_reg.fault);
				check_bit("ma_was_load", ma_was_load, exp_reg.load);
				check_bit("ma_was_io", ma_was_io, exp_reg.was_io);
				check_line("ma_result", ma_result, exp_reg.result);
				check_word("ma_strand", 32'(ma_strand), 32'(exp_reg.strand));
				check_word("ma_pc", ma_pc, exp_reg.pc);
				check_word("ma_writeback_reg", 32'(ma_writeback_reg), 32'(exp_reg.wb_reg));
				check_word("ma_mask", 32'(ma_mask), 32'(exp_reg.mask));
				check_word("ma_reg_lane_select", 32'(ma_reg_lane_select),
					32'(exp_reg.reg_lane));
				check_word("ma_cache_lane_select", 32'(ma_cache_lane_select),
					32'(exp_reg.cache_lane));
				check_word("ma_strided_offset", ma_strided_offset, exp_reg.offset);
			end
			@(posedge clk);
			cycles++;
			if (cycles > 1000)
				fail_run("compare process ran past 1000 cycles");
		end
		checks_done = 1'b1;
	end

endmodule
